/* Bender.yml */
package:
  name: mac_subsystem

sources:
  # RTL, package first
  - hdl/mac_pkg.sv
  - hdl/pair_if.sv
  - hdl/operand_pairing.sv
  - hdl/operand_fifo.sv
  - hdl/mac_accumulator.sv
  - hdl/mac_top.sv

  # Testbench, top module mac_tb
  - target: simulation
    files:
      - sim/mac_properties.sv
      - sim/mac_checker.sv
      - sim/mac_tb.sv

/* hdl/mac_accumulator.sv */
`timescale 1ns/1ps

module mac_accumulator (
   input  logic          clk,
   input  logic          rst_n,
   pair_rd_if.consumer   rd,
   input  logic          mac_en,
   input  logic          acc_clr,
   output mac_pkg::acc_t data_p,
   output logic          p_valid
);

   // Operand stage, like A1/B1
   mac_pkg::operand_t a1;
   mac_pkg::operand_t b1;
   logic              v1;

   // Multiplier stage, like M
   mac_pkg::product_t m_reg;
   logic              v2;

   mac_pkg::acc_t     m_ext;   // Product widened to the accumulator

   // mac_en gates entry only; pairs already inside drain out
   assign rd.pop = mac_en & ~rd.empty;

   // Signed cast extends the sign bit
   assign m_ext = mac_pkg::acc_t'(m_reg);

   // Datapath registers
   always_ff @(posedge clk) begin
      if (rd.pop) begin
         a1 <= rd.a;   // Head captured on the pop edge
         b1 <= rd.b;
      end
      if (v1) begin
         m_reg <= a1 * b1;   // 36-bit signed context
      end
   end

   // Stage valids
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         v1 <= 1'b0;
         v2 <= 1'b0;
      end else begin
         v1 <= rd.pop;
         v2 <= v1;
      end
   end

   // P stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         data_p  <= '0;
         p_valid <= 1'b0;
      end else begin
         p_valid <= v2;   // One pulse per product
         if (acc_clr) begin
            // Clear wins, but a product arriving now becomes the new start
            data_p <= v2 ? m_ext : '0;
         end else if (v2) begin
            data_p <= data_p + m_ext;   // Wraps modulo 2**48
         end
      end
   end

endmodule

/* hdl/mac_pkg.sv */
package mac_pkg;

   // Datapath widths, sized after the DSP slice this block replaces
   localparam int OPERAND_W = 18;
   localparam int PRODUCT_W = 2 * OPERAND_W;   // Full signed product
   localparam int ACC_W     = 48;              // P register width

   typedef logic signed [OPERAND_W-1:0] operand_t;   // A and B operands
   typedef logic signed [PRODUCT_W-1:0] product_t;   // M stage
   typedef logic signed [ACC_W-1:0]     acc_t;       // P stage, wraps mod 2**48

   // Pair FIFO depth unless the top level overrides it
   localparam int DEPTH_DEFAULT = 4;

   // Per-operand hold slot in the pairing stage
   typedef enum logic {
      SLOT_EMPTY,   // Ready for a new strobe
      SLOT_HELD     // Waiting for the partner operand
   } state_t;

endpackage

/* hdl/mac_top.sv */
`timescale 1ns/1ps

module mac_top #(
   parameter int FIFO_DEPTH = mac_pkg::DEPTH_DEFAULT
) (
   input  logic              clk,
   input  logic              rst_n,
   input  mac_pkg::operand_t data_a,
   input  logic              a_valid,
   input  mac_pkg::operand_t data_b,
   input  logic              b_valid,
   input  logic              mac_en,    // Consumer enable
   input  logic              acc_clr,   // Restart accumulation
   output logic              a_ready,
   output logic              b_ready,
   output mac_pkg::acc_t     data_p,
   output logic              p_valid
);

   pair_wr_if u_wr_if ();   // Pairing to FIFO
   pair_rd_if u_rd_if ();   // FIFO to MAC

   // Producer, one hold slot per operand
   operand_pairing u_pairing (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_a  (data_a),
      .a_valid (a_valid),
      .data_b  (data_b),
      .b_valid (b_valid),
      .a_ready (a_ready),
      .b_ready (b_ready),
      .wr      (u_wr_if.producer)
   );

   // Buffer, absorbs pairs while mac_en is low
   operand_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (u_wr_if.buffer),
      .rd    (u_rd_if.buffer)
   );

   // Consumer, three-stage MAC
   mac_accumulator u_mac (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd      (u_rd_if.consumer),
      .mac_en  (mac_en),
      .acc_clr (acc_clr),
      .data_p  (data_p),
      .p_valid (p_valid)
   );

endmodule

/* hdl/operand_fifo.sv */
`timescale 1ns/1ps

module operand_fifo #(
   parameter int FIFO_DEPTH = mac_pkg::DEPTH_DEFAULT
) (
   input  logic      clk,
   input  logic      rst_n,
   pair_wr_if.buffer wr,
   pair_rd_if.buffer rd
);

   // Pointer needs at least one bit even for depth 1
   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);   // Holds 0..FIFO_DEPTH

   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

   mac_pkg::operand_t mem_a [FIFO_DEPTH];   // A half of each pair
   mac_pkg::operand_t mem_b [FIFO_DEPTH];   // B half of each pair

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;   // Pairs stored
   logic             do_wr;
   logic             do_rd;

   // Status from occupancy
   assign rd.empty = (count == '0);
   assign wr.full  = (count == CNT_FULL);

   // Guard both sides against protocol slips
   assign do_wr = wr.push & ~wr.full;
   assign do_rd = rd.pop & ~rd.empty;

   // Head always on the read port
   assign rd.a = mem_a[rd_ptr];
   assign rd.b = mem_b[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem_a[wr_ptr] <= wr.a;
         mem_b[wr_ptr] <= wr.b;
      end
   end

   // Pointers wrap at the last slot, so any depth works
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // Occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;   // Write only
            2'b01:   count <= count - 1'b1;   // Read only
            default: count <= count;          // Both or neither, level unchanged
         endcase
      end
   end

endmodule

/* hdl/operand_pairing.sv */
`timescale 1ns/1ps

module operand_pairing (
   input  logic              clk,
   input  logic              rst_n,
   input  mac_pkg::operand_t data_a,
   input  logic              a_valid,
   input  mac_pkg::operand_t data_b,
   input  logic              b_valid,
   output logic              a_ready,
   output logic              b_ready,
   pair_wr_if.producer       wr
);

   mac_pkg::state_t   a_state;   // Slot for A
   mac_pkg::state_t   b_state;   // Slot for B
   mac_pkg::operand_t a_hold;
   mac_pkg::operand_t b_hold;
   logic              a_load;
   logic              b_load;
   logic              pair_go;   // Both held and FIFO has room

   // Ready is simply the slot being free
   assign a_ready = (a_state == mac_pkg::SLOT_EMPTY);
   assign b_ready = (b_state == mac_pkg::SLOT_EMPTY);

   // Strobes only count into an empty slot
   assign a_load = a_valid & a_ready;
   assign b_load = b_valid & b_ready;

   assign pair_go = (a_state == mac_pkg::SLOT_HELD) &
                    (b_state == mac_pkg::SLOT_HELD) & ~wr.full;

   // Push in the same cycle the pair completes
   assign wr.push = pair_go;
   assign wr.a    = a_hold;
   assign wr.b    = b_hold;

   // Operand capture
   always_ff @(posedge clk) begin
      if (a_load) begin
         a_hold <= data_a;
      end
      if (b_load) begin
         b_hold <= data_b;
      end
   end

   // Slot state
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_state <= mac_pkg::SLOT_EMPTY;
         b_state <= mac_pkg::SLOT_EMPTY;
      end else begin
         // A full slot waits here while the FIFO is full
         if (pair_go) begin
            a_state <= mac_pkg::SLOT_EMPTY;   // Pair handed over
            b_state <= mac_pkg::SLOT_EMPTY;
         end else begin
            if (a_load) begin
               a_state <= mac_pkg::SLOT_HELD;
            end
            if (b_load) begin
               b_state <= mac_pkg::SLOT_HELD;
            end
         end
      end
   end

endmodule

/* hdl/pair_if.sv */
`timescale 1ns/1ps

// Write side of the pair FIFO
interface pair_wr_if;
   logic              push;   // One-cycle write strobe
   mac_pkg::operand_t a;      // Operand A of the pair
   mac_pkg::operand_t b;      // Operand B of the pair
   logic              full;   // No room for another pair

   modport producer (
      output push,
      output a,
      output b,
      input  full
   );

   modport buffer (
      input  push,
      input  a,
      input  b,
      output full
   );
endinterface

// Read side, head pair shown while not empty
interface pair_rd_if;
   logic              pop;     // Consume head on this edge
   mac_pkg::operand_t a;      // Head operand A
   mac_pkg::operand_t b;      // Head operand B
   logic              empty;   // Head not valid

   modport buffer (
      input  pop,
      output a,
      output b,
      output empty
   );

   modport consumer (
      output pop,
      input  a,
      input  b,
      input  empty
   );
endinterface

/* sim/mac_checker.sv */
`timescale 1ns/1ps

module mac_checker (
   input  logic              clk,
   input  logic              rst_n,
   input  mac_pkg::operand_t data_a,
   input  logic              a_valid,
   input  logic              a_ready,
   input  mac_pkg::operand_t data_b,
   input  logic              b_valid,
   input  logic              b_ready,
   input  logic              acc_clr,
   input  mac_pkg::acc_t     data_p,
   input  logic              p_valid,
   input  logic              end_check,      // Level, queue check runs once
   output int                error_count,
   output int                result_count,   // p_valid pulses seen
   output int                a_count,        // Accepted A strobes
   output int                b_count         // Accepted B strobes
);

   mac_pkg::operand_t qa [$];   // Accepted A, oldest first
   mac_pkg::operand_t qb [$];
   mac_pkg::acc_t     model_acc;     // Expected running sum
   logic              clr_pending;   // Clear seen, not yet applied
   logic              end_done;

   // Previous sum (or zero after a clear) plus the sign-extended product
   function automatic mac_pkg::acc_t ref_mac(input mac_pkg::acc_t prev, input logic clr,
                                             input mac_pkg::operand_t a,
                                             input mac_pkg::operand_t b);
      longint prod;
      longint base;
      prod = longint'(a) * longint'(b);       // Exact, fits easily in 64 bits
      base = clr ? 64'sd0 : longint'(prev);
      return mac_pkg::acc_t'(base + prod);    // Keep low 48 bits, mod 2**48
   endfunction

   // Samples pre-edge values, so p_valid here belongs to the previous edge
   always @(posedge clk) begin : compare
      mac_pkg::acc_t     expected;
      mac_pkg::operand_t a;
      mac_pkg::operand_t b;
      if (!rst_n) begin
         qa.delete();
         qb.delete();
         model_acc    = '0;
         clr_pending  = 1'b0;
         end_done     = 1'b0;
         error_count  = 0;
         result_count = 0;
         a_count      = 0;
         b_count      = 0;
      end else begin
         if (p_valid) begin
            if (qa.size() == 0 || qb.size() == 0) begin
               $display("Result on data_p with no accepted operand pair behind it");
               error_count++;
            end else begin
               a = qa.pop_front();   // Pairs form in acceptance order
               b = qb.pop_front();
               expected = ref_mac(model_acc, clr_pending, a, b);
               clr_pending = 1'b0;
               if (data_p !== expected) begin
                  $display("ERROR data_p expected %h actual %h", expected, data_p);
                  error_count++;
               end
               model_acc = expected;
            end
            result_count++;
         end
         // A clear this edge applies to the product in P now or the next one
         if (acc_clr) begin
            clr_pending = 1'b1;
         end
         if (a_valid && a_ready) begin
            qa.push_back(data_a);
            a_count++;
         end
         if (b_valid && b_ready) begin
            qb.push_back(data_b);
            b_count++;
         end
         if (end_check && !end_done) begin
            end_done = 1'b1;
            if (qa.size() != 0 || qb.size() != 0) begin
               $display("%0d A and %0d B operands were accepted but never accumulated",
                        qa.size(), qb.size());
               error_count++;
            end
         end
      end
   end

endmodule

/* sim/mac_properties.sv */
`timescale 1ns/1ps

module mac_properties (
   input logic clk,
   input logic rst_n,
   input logic p_valid,   // P stage output strobe
   input logic pop,       // FIFO read strobe from the MAC
   input logic empty,     // FIFO head not valid
   input logic push,      // FIFO write strobe from pairing
   input logic full       // FIFO has no room
);

   int fail_count = 0;   // Assertion failures so far

   // No result leaves the P stage while reset is held
   p_valid_in_reset: assert property (
      @(posedge clk) !rst_n |-> !p_valid
   ) else begin
      $error("p_valid high while reset is asserted");
      fail_count++;
   end

   // MAC only takes a head that exists
   pop_when_empty: assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> !empty
   ) else begin
      $error("pop raised while the FIFO is empty");
      fail_count++;
   end

   // Pairing never writes into a full FIFO
   push_when_full: assert property (
      @(posedge clk) disable iff (!rst_n) push |-> !full
   ) else begin
      $error("push raised while the FIFO is full");
      fail_count++;
   end

endmodule

/* sim/mac_tb.sv */
`timescale 1ns/1ps

module mac_tb;

   localparam int WAIT_LIMIT = 500;   // Cycles before any wait gives up
   localparam int N_RAND     = 200;

   logic              clk = 1'b0;
   logic              rst_n;
   mac_pkg::operand_t data_a;
   logic              a_valid;
   mac_pkg::operand_t data_b;
   logic              b_valid;
   logic              mac_en;
   logic              acc_clr;
   logic              a_ready;
   logic              b_ready;
   mac_pkg::acc_t     data_p;
   logic              p_valid;
   logic              end_check;

   int error_count;   // From the checker
   int result_count;
   int a_count;
   int b_count;

   int          tb_errors;
   int          err_mark;       // Error total at the end of the last test
   int          test_num;
   int          tests_failed;
   logic        timed_out;
   logic        senders_done;
   logic [31:0] lfsr;

   mac_pkg::operand_t rnd_a [N_RAND];
   mac_pkg::operand_t rnd_b [N_RAND];
   int                gap_a [N_RAND];   // Idle cycles before each strobe
   int                gap_b [N_RAND];

   always #5 clk = ~clk;   // 10 ns period

   mac_top #(
      .FIFO_DEPTH (4)
   ) u_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_a  (data_a),
      .a_valid (a_valid),
      .data_b  (data_b),
      .b_valid (b_valid),
      .mac_en  (mac_en),
      .acc_clr (acc_clr),
      .a_ready (a_ready),
      .b_ready (b_ready),
      .data_p  (data_p),
      .p_valid (p_valid)
   );

   mac_checker u_chk (
      .clk          (clk),
      .rst_n        (rst_n),
      .data_a       (data_a),
      .a_valid      (a_valid),
      .a_ready      (a_ready),
      .data_b       (data_b),
      .b_valid      (b_valid),
      .b_ready      (b_ready),
      .acc_clr      (acc_clr),
      .data_p       (data_p),
      .p_valid      (p_valid),
      .end_check    (end_check),
      .error_count  (error_count),
      .result_count (result_count),
      .a_count      (a_count),
      .b_count      (b_count)
   );

   // Handshake and reset checks sit on the MAC, write side seen one level up
   bind mac_accumulator mac_properties u_props (
      .clk     (clk),
      .rst_n   (rst_n),
      .p_valid (p_valid),
      .pop     (rd.pop),
      .empty   (rd.empty),
      .push    (u_wr_if.push),
      .full    (u_wr_if.full)
   );

   // x^32 + x^22 + x^2 + x + 1, one step per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // Checker mismatches, assertion failures and direct checks together
   function automatic int total_errors();
      return tb_errors + error_count + u_dut.u_mac.u_props.fail_count;
   endfunction

   task automatic step();
      @(posedge clk);
      #1;   // Inputs change well clear of the edge
   endtask

   task automatic finish_run();
      $display("Summary: %0d tests, %0d failed, %0d results checked, %0d errors",
               test_num, tests_failed, result_count, total_errors());
      if (tests_failed == 0 && !timed_out && total_errors() == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   endtask

   task automatic wait_failed(input string what);
      $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
      timed_out = 1'b1;
      finish_run();
   endtask

   task automatic check_eq(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR %s expected %h actual %h", name, expected, actual);
         tb_errors++;
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = total_errors();
      test_num++;
      if (errs == err_mark) begin
         $display("Test %0d %s: ok", test_num, name);
      end else begin
         $display("Test %0d %s: %0d errors", test_num, name, errs - err_mark);
         tests_failed++;
      end
      err_mark = errs;
   endtask

   task automatic send_a(input mac_pkg::operand_t v);
      int n;
      n = 0;
      while (!a_ready) begin   // Slot still held
         if (n == WAIT_LIMIT) wait_failed("a_ready");
         step();
         n++;
      end
      data_a  = v;
      a_valid = 1'b1;
      step();
      a_valid = 1'b0;
   endtask

   task automatic send_b(input mac_pkg::operand_t v);
      int n;
      n = 0;
      while (!b_ready) begin
         if (n == WAIT_LIMIT) wait_failed("b_ready");
         step();
         n++;
      end
      data_b  = v;
      b_valid = 1'b1;
      step();
      b_valid = 1'b0;
   endtask

   // Both operands strobed in one cycle
   task automatic send_pair(input mac_pkg::operand_t va, input mac_pkg::operand_t vb);
      int n;
      n = 0;
      while (!(a_ready && b_ready)) begin
         if (n == WAIT_LIMIT) wait_failed("a_ready and b_ready");
         step();
         n++;
      end
      data_a  = va;
      data_b  = vb;
      a_valid = 1'b1;
      b_valid = 1'b1;
      step();
      a_valid = 1'b0;
      b_valid = 1'b0;
   endtask

   // Every accepted pair has come out as a result
   task automatic wait_drain();
      int n;
      n = 0;
      while (!(a_count == b_count && result_count == a_count)) begin
         if (n == WAIT_LIMIT) wait_failed("all accepted pairs to be accumulated");
         step();
         n++;
      end
   endtask

   initial begin
      int results_before;
      rst_n        = 1'b0;
      data_a       = '0;
      a_valid      = 1'b0;
      data_b       = '0;
      b_valid      = 1'b0;
      mac_en       = 1'b0;
      acc_clr      = 1'b0;
      end_check    = 1'b0;
      tb_errors    = 0;
      err_mark     = 0;
      test_num     = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      senders_done = 1'b0;
      lfsr         = 32'h8f23b697;

      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      step();

      // 1: idle outputs straight out of reset
      check_eq("data_p", data_p, '0);
      check_eq("p_valid", p_valid, 0);
      check_eq("a_ready", a_ready, 1);
      check_eq("b_ready", b_ready, 1);
      end_test("reset state");

      // 2: same-cycle pairs, corners of the signed range
      mac_en = 1'b1;
      send_pair(18'sd3, 18'sd4);
      send_pair(-18'sd5, 18'sd7);
      send_pair(18'sd131071, -18'sd131072);
      send_pair(-18'sd131072, -18'sd131072);
      send_pair(-18'sd1, -18'sd1);
      wait_drain();
      end_test("directed same-cycle pairs");

      // 3: split strobes, second A queued behind a held slot
      send_a(18'sd10);
      check_eq("a_ready", a_ready, 0);   // Slot held until B shows up
      check_eq("b_ready", b_ready, 1);
      fork
         send_a(-18'sd30);   // Stalls on a_ready
         begin
            repeat (3) step();
            send_b(18'sd20);
         end
      join
      send_b(-18'sd7);
      send_b(18'sd5);                    // B ahead of its A this time
      check_eq("b_ready", b_ready, 0);
      send_a(18'sd9);
      wait_drain();
      end_test("split strobes");

      // 4: MAC paused, FIFO and slots fill
      mac_en = 1'b0;
      results_before = result_count;
      for (int i = 0; i < 5; i++) begin
         send_pair(mac_pkg::operand_t'(100 + i), mac_pkg::operand_t'(-3 - i));
      end
      repeat (3) step();
      check_eq("a_ready", a_ready, 0);
      check_eq("b_ready", b_ready, 0);
      check_eq("p_valid count", result_count, results_before);
      fork
         begin
            send_pair(18'sd77, -18'sd11);   // Held back until space returns
            send_pair(-18'sd500, 18'sd1234);
         end
         begin
            repeat (4) step();
            mac_en = 1'b1;
         end
      join
      wait_drain();
      end_test("back-pressure");

      // 5: clear while idle, next result is one product alone
      acc_clr = 1'b1;
      step();
      acc_clr = 1'b0;
      send_pair(-18'sd1234, 18'sd567);
      wait_drain();
      check_eq("data_p", data_p, mac_pkg::acc_t'(-64'sd1234 * 64'sd567));
      end_test("accumulator clear");

      // 6: random operands, gaps and mac_en
      for (int i = 0; i < N_RAND; i++) begin
         rnd_a[i] = mac_pkg::operand_t'(lfsr_bits(18));
         rnd_b[i] = mac_pkg::operand_t'(lfsr_bits(18));
         gap_a[i] = int'(lfsr_bits(2));
         gap_b[i] = int'(lfsr_bits(2));
      end
      fork
         begin
            fork
               for (int i = 0; i < N_RAND; i++) begin
                  repeat (gap_a[i]) step();
                  send_a(rnd_a[i]);
               end
               for (int j = 0; j < N_RAND; j++) begin
                  repeat (gap_b[j]) step();
                  send_b(rnd_b[j]);
               end
            join
            senders_done = 1'b1;
         end
         begin
            int n;
            n = 0;
            while (!senders_done) begin
               if (n == N_RAND * WAIT_LIMIT) wait_failed("random senders to finish");
               mac_en = (lfsr_bits(2) != 0);   // On about three cycles in four
               step();
               n++;
            end
            mac_en = 1'b1;
         end
      join
      wait_drain();
      end_check = 1'b1;   // Checker confirms nothing is left queued
      step();
      step();
      end_test("random pairs");

      finish_run();
   end

endmodule

/* tb.f */
hdl/mac_pkg.sv
hdl/pair_if.sv
hdl/operand_pairing.sv
hdl/operand_fifo.sv
hdl/mac_accumulator.sv
hdl/mac_top.sv
sim/mac_properties.sv
sim/mac_checker.sv
sim/mac_tb.sv
